// ==== hdl/ship_kbd_pkg.sv ====
// scan-code type and constants, frame sizes, receiver/tracker/command enums, seven-segment patterns
package ship_kbd_pkg;

	typedef logic [7:0] scan_t;   // one byte off the ps2 line
	typedef logic [6:0] seg_t;    // active low, bit 0 is segment a

	// special codes seen by the mode tracker
	localparam scan_t scan_break   = 8'hf0; // key release prefix
	localparam scan_t scan_shift_l = 8'h12;
	localparam scan_t scan_shift_r = 8'h59;
	localparam scan_t scan_caps    = 8'h58;

	localparam logic [3:0] frame_bits   = 4'd10; // 8 data + parity + stop, start bit not counted
	localparam int unsigned filter_len  = 8;     // ps2c samples needed before the filter flips
	localparam logic [1:0] caps_presses = 2'd3;  // caps codes left after the first press

	// receiver fsm
	typedef enum logic {
		rx_idle,
		rx_shift
	} rx_state_e;

	// key mode tracker
	typedef enum logic [2:0] {
		mode_lower,             // plain keys
		mode_skip_break,        // drop make code after F0
		mode_shift,             // shift held
		mode_skip_shift_break,  // after F0 in shift, check for shift release
		mode_caps,              // caps lock active
		mode_skip_caps_break    // after F0 in caps, count caps releases
	} key_mode_e;

	// ship commands, 0 is unused
	typedef enum logic [3:0] {
		cmd_left      = 4'd1,
		cmd_right     = 4'd2,
		cmd_down      = 4'd3,
		cmd_up        = 4'd4,
		cmd_fire      = 4'd5,
		cmd_alt_up    = 4'd6,  // arrow keys, second player set
		cmd_alt_left  = 4'd7,
		cmd_alt_down  = 4'd8,
		cmd_alt_right = 4'd9
	} ship_cmd_e;

	// key table, one make code per command
	localparam scan_t key_a           = 8'h1c;
	localparam scan_t key_d           = 8'h23;
	localparam scan_t key_s           = 8'h1b;
	localparam scan_t key_w           = 8'h1d;
	localparam scan_t key_space       = 8'h29;
	localparam scan_t key_up_arrow    = 8'h75;
	localparam scan_t key_left_arrow  = 8'h6b;
	localparam scan_t key_down_arrow  = 8'h72;
	localparam scan_t key_right_arrow = 8'h74;

	// hex digit patterns per command
	localparam seg_t seg_left  = 7'b1011111;
	localparam seg_t seg_right = 7'b1111101;
	localparam seg_t seg_down  = 7'b0111111;
	localparam seg_t seg_up    = 7'b1111110;
	localparam seg_t seg_fire  = 7'b1110111;
	localparam seg_t seg_other = 7'b1101011; // all alternate commands

endpackage

// ==== hdl/ps2_rx.sv ====
// ps2 receiver with ps2c de-glitch filter, falling-edge detect and 11-bit frame shift fsm
`timescale 1ns/1ps

module ps2_rx
(
	input  logic                clk,
	input  logic                reset,
	input  logic                ps2c,     // async keyboard clock
	input  logic                ps2d,     // async keyboard data
	output ship_kbd_pkg::scan_t rx_data,  // data bits of last frame
	output logic                rx_done   // one cycle at end of frame
);

	localparam int unsigned cnt_w = $bits(ship_kbd_pkg::frame_bits);

	// clock filter
	logic [ship_kbd_pkg::filter_len-1:0] filter_reg;
	logic [ship_kbd_pkg::filter_len-1:0] filter_next;
	logic filt_val;       // de-glitched ps2c
	logic filt_val_next;
	logic neg_edge;       // filtered ps2c going 1 -> 0

	// frame fsm
	ship_kbd_pkg::rx_state_e state_reg;
	ship_kbd_pkg::rx_state_e state_next;
	logic [cnt_w-1:0] bit_cnt;        // bits still to come
	logic [cnt_w-1:0] bit_cnt_next;
	logic [ship_kbd_pkg::frame_bits:0] shift_reg;   // stop, parity, data, stale lsb
	logic [ship_kbd_pkg::frame_bits:0] shift_next;

	// newest sample enters at the top
	assign filter_next = {ps2c, filter_reg[ship_kbd_pkg::filter_len-1:1]};

	// flips only on a full run of equal samples and holds otherwise
	always_comb
	begin
		filt_val_next = filt_val;
		if (filter_reg == '1)
			filt_val_next = 1'b1;
		else if (filter_reg == '0)
			filt_val_next = 1'b0;
	end

	assign neg_edge = filt_val & ~filt_val_next;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			filter_reg <= '0;
			filt_val   <= 1'b0;
		end
		else
		begin
			filter_reg <= filter_next;
			filt_val   <= filt_val_next;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_reg <= ship_kbd_pkg::rx_idle;
			bit_cnt   <= '0;
		end
		else
		begin
			state_reg <= state_next;
			bit_cnt   <= bit_cnt_next;
		end
	end

	// frame data shifter
	always_ff @(posedge clk)
	begin
		shift_reg <= shift_next;
	end

	always_comb
	begin
		state_next   = state_reg;
		bit_cnt_next = bit_cnt;
		shift_next   = shift_reg;
		rx_done      = 1'b0;
		unique case (state_reg)
			ship_kbd_pkg::rx_idle:
			begin
				if (neg_edge) // start bit
				begin
					bit_cnt_next = ship_kbd_pkg::frame_bits;
					state_next   = ship_kbd_pkg::rx_shift;
				end
			end
			ship_kbd_pkg::rx_shift:
			begin
				if (bit_cnt == '0) // stop bit already in
				begin
					rx_done    = 1'b1;
					state_next = ship_kbd_pkg::rx_idle;
				end
				else if (neg_edge)
				begin
					shift_next   = {ps2d, shift_reg[ship_kbd_pkg::frame_bits:1]}; // lsb first
					bit_cnt_next = bit_cnt - 1'b1;
				end
			end
			default:
				state_next = ship_kbd_pkg::rx_idle;
		endcase
	end

	// parity at bit 9 and stop at bit 10 go unchecked
	assign rx_data = shift_reg[8:1];

endmodule

// ==== hdl/key_mode_fsm.sv ====
// key mode tracker: break-code skipping, shift and caps-lock modes, valid key pulse, case level
`timescale 1ns/1ps

module key_mode_fsm
(
	input  logic                clk,
	input  logic                reset,
	input  ship_kbd_pkg::scan_t rx_data,
	input  logic                rx_done,
	output ship_kbd_pkg::scan_t scan_code,
	output logic                key_valid,  // real key press, same cycle as rx_done
	output logic                upper_case
);

	ship_kbd_pkg::key_mode_e state_reg;
	ship_kbd_pkg::key_mode_e state_next;
	ship_kbd_pkg::scan_t shift_code;       // which shift key put us in shift mode
	ship_kbd_pkg::scan_t shift_code_next;
	logic [1:0] caps_cnt;                  // caps codes until caps mode ends
	logic [1:0] caps_cnt_next;

	logic is_shift;
	logic is_caps;
	logic is_break;

	// classify incoming code
	assign is_shift = (rx_data == ship_kbd_pkg::scan_shift_l) ||
		(rx_data == ship_kbd_pkg::scan_shift_r);
	assign is_caps  = (rx_data == ship_kbd_pkg::scan_caps);
	assign is_break = (rx_data == ship_kbd_pkg::scan_break);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_reg  <= ship_kbd_pkg::mode_lower;
			shift_code <= '0;
			caps_cnt   <= '0;
		end
		else
		begin
			state_reg  <= state_next;
			shift_code <= shift_code_next;
			caps_cnt   <= caps_cnt_next;
		end
	end

	always_comb
	begin
		state_next      = state_reg;
		shift_code_next = shift_code;
		caps_cnt_next   = caps_cnt;
		key_valid       = 1'b0;
		unique case (state_reg)
			ship_kbd_pkg::mode_lower:
			begin
				if (rx_done)
				begin
					if (is_shift)
					begin
						shift_code_next = rx_data; // remember left or right
						state_next      = ship_kbd_pkg::mode_shift;
					end
					else if (is_caps)
					begin
						caps_cnt_next = ship_kbd_pkg::caps_presses;
						state_next    = ship_kbd_pkg::mode_caps;
					end
					else if (is_break)
						state_next = ship_kbd_pkg::mode_skip_break;
					else
						key_valid = 1'b1;
				end
			end
			ship_kbd_pkg::mode_skip_break:
			begin
				if (rx_done) // repeated make code of the released key
					state_next = ship_kbd_pkg::mode_lower;
			end
			ship_kbd_pkg::mode_shift:
			begin
				if (rx_done)
				begin
					if (is_break)
						state_next = ship_kbd_pkg::mode_skip_shift_break;
					else if (!is_shift && !is_caps) // typematic shift repeats dropped
						key_valid = 1'b1;
				end
			end
			ship_kbd_pkg::mode_skip_shift_break:
			begin
				if (rx_done)
				begin
					if (rx_data == shift_code) // shift let go
						state_next = ship_kbd_pkg::mode_lower;
					else                       // some other key released
						state_next = ship_kbd_pkg::mode_shift;
				end
			end
			ship_kbd_pkg::mode_caps:
			begin
				if (caps_cnt == '0)
					state_next = ship_kbd_pkg::mode_lower;
				if (rx_done)
				begin
					if (is_caps)
						caps_cnt_next = caps_cnt - 1'b1; // second press
					else if (is_break)
						state_next = ship_kbd_pkg::mode_skip_caps_break;
					else if (!is_shift)
						key_valid = 1'b1;
				end
			end
			ship_kbd_pkg::mode_skip_caps_break:
			begin
				if (rx_done)
				begin
					if (is_caps) // caps release counts too
						caps_cnt_next = caps_cnt - 1'b1;
					state_next = ship_kbd_pkg::mode_caps;
				end
			end
			default:
				state_next = ship_kbd_pkg::mode_lower;
		endcase
	end

	// moore, low in the skip states
	assign upper_case = (state_reg == ship_kbd_pkg::mode_shift) ||
		(state_reg == ship_kbd_pkg::mode_caps);

	assign scan_code = rx_data;

endmodule

// ==== hdl/ship_command_decode.sv ====
// ship command decoder: key table lookup on valid keys, registered command, segment pattern
`timescale 1ns/1ps

module ship_command_decode
(
	input  logic                    clk,
	input  logic                    reset,
	input  ship_kbd_pkg::scan_t     scan_code,
	input  logic                    key_valid,
	output ship_kbd_pkg::ship_cmd_e ship_cmd,
	output ship_kbd_pkg::seg_t      hex_seg
);

	ship_kbd_pkg::ship_cmd_e cmd_lookup; // table result for the current code

	// make code to command, anything unknown steers up
	always_comb
	begin
		case (scan_code)
			ship_kbd_pkg::key_a:           cmd_lookup = ship_kbd_pkg::cmd_left;
			ship_kbd_pkg::key_d:           cmd_lookup = ship_kbd_pkg::cmd_right;
			ship_kbd_pkg::key_s:           cmd_lookup = ship_kbd_pkg::cmd_down;
			ship_kbd_pkg::key_w:           cmd_lookup = ship_kbd_pkg::cmd_up;
			ship_kbd_pkg::key_space:       cmd_lookup = ship_kbd_pkg::cmd_fire;
			ship_kbd_pkg::key_up_arrow:    cmd_lookup = ship_kbd_pkg::cmd_alt_up;
			ship_kbd_pkg::key_left_arrow:  cmd_lookup = ship_kbd_pkg::cmd_alt_left;
			ship_kbd_pkg::key_down_arrow:  cmd_lookup = ship_kbd_pkg::cmd_alt_down;
			ship_kbd_pkg::key_right_arrow: cmd_lookup = ship_kbd_pkg::cmd_alt_right;
			default:                       cmd_lookup = ship_kbd_pkg::cmd_up;
		endcase
	end

	// hold last accepted command
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ship_cmd <= ship_kbd_pkg::cmd_up;
		else if (key_valid)
			ship_cmd <= cmd_lookup;
	end

	// one hex digit shows the direction
	always_comb
	begin
		case (ship_cmd)
			ship_kbd_pkg::cmd_left:      hex_seg = ship_kbd_pkg::seg_left;
			ship_kbd_pkg::cmd_right:     hex_seg = ship_kbd_pkg::seg_right;
			ship_kbd_pkg::cmd_down:      hex_seg = ship_kbd_pkg::seg_down;
			ship_kbd_pkg::cmd_up:        hex_seg = ship_kbd_pkg::seg_up;
			ship_kbd_pkg::cmd_fire:      hex_seg = ship_kbd_pkg::seg_fire;
			ship_kbd_pkg::cmd_alt_up,
			ship_kbd_pkg::cmd_alt_left,
			ship_kbd_pkg::cmd_alt_down,
			ship_kbd_pkg::cmd_alt_right: hex_seg = ship_kbd_pkg::seg_other;
			default:                     hex_seg = ship_kbd_pkg::seg_other;
		endcase
	end

endmodule

// ==== hdl/ship_kbd_top.sv ====
// keyboard front end top: ps2 receiver, key mode tracker and ship command decoder
`timescale 1ns/1ps

module ship_kbd_top
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    ps2c,
	input  logic                    ps2d,
	output ship_kbd_pkg::scan_t     scan_code,
	output logic                    key_valid,
	output logic                    upper_case,
	output ship_kbd_pkg::ship_cmd_e ship_cmd,
	output ship_kbd_pkg::seg_t      hex_seg
);

	ship_kbd_pkg::scan_t rx_data; // raw byte from receiver
	logic rx_done;

	ps2_rx i_ps2_rx (
		.clk     (clk),
		.reset   (reset),
		.ps2c    (ps2c),
		.ps2d    (ps2d),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	key_mode_fsm i_key_mode_fsm (
		.clk        (clk),
		.reset      (reset),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.scan_code  (scan_code),
		.key_valid  (key_valid),
		.upper_case (upper_case)
	);

	ship_command_decode i_ship_command_decode (
		.clk       (clk),
		.reset     (reset),
		.scan_code (scan_code),
		.key_valid (key_valid),
		.ship_cmd  (ship_cmd),
		.hex_seg   (hex_seg)
	);

endmodule

// ==== dv/ship_kbd_checker.sv ====
// testbench checker: reference model of frames, key modes and command table, output compares
`timescale 1ns/1ps

module ship_kbd_checker
(
	input logic                    clk,
	input logic                    reset,
	input logic                    rx_done,    // receiver pulse inside the dut
	input ship_kbd_pkg::scan_t     scan_code,
	input logic                    key_valid,
	input logic                    upper_case,
	input ship_kbd_pkg::ship_cmd_e ship_cmd,
	input ship_kbd_pkg::seg_t      hex_seg
);

	ship_kbd_pkg::scan_t sent_byte;  // set by the frame driver just before a frame
	event byte_sent;
	ship_kbd_pkg::scan_t exp_q[$];   // frames on the wire, oldest first
	int unsigned value_errors = 0;
	int unsigned other_errors = 0;
	int unsigned frames_seen  = 0;

	// model state, mirrors the tracker rules
	ship_kbd_pkg::key_mode_e mode;
	ship_kbd_pkg::scan_t     held_shift;
	int                      caps_left;
	ship_kbd_pkg::ship_cmd_e exp_cmd;

	// key table, same order as the command list
	ship_kbd_pkg::scan_t key_tab [9] = '{ship_kbd_pkg::key_a, ship_kbd_pkg::key_d,
		ship_kbd_pkg::key_s, ship_kbd_pkg::key_w, ship_kbd_pkg::key_space,
		ship_kbd_pkg::key_up_arrow, ship_kbd_pkg::key_left_arrow,
		ship_kbd_pkg::key_down_arrow, ship_kbd_pkg::key_right_arrow};
	ship_kbd_pkg::ship_cmd_e cmd_tab [9] = '{ship_kbd_pkg::cmd_left, ship_kbd_pkg::cmd_right,
		ship_kbd_pkg::cmd_down, ship_kbd_pkg::cmd_up, ship_kbd_pkg::cmd_fire,
		ship_kbd_pkg::cmd_alt_up, ship_kbd_pkg::cmd_alt_left,
		ship_kbd_pkg::cmd_alt_down, ship_kbd_pkg::cmd_alt_right};

	function automatic ship_kbd_pkg::ship_cmd_e cmd_for_key(input ship_kbd_pkg::scan_t code);
		ship_kbd_pkg::ship_cmd_e result;
		result = ship_kbd_pkg::cmd_up; // unknown codes steer up
		for (int i = 0; i < 9; i++)
			if (key_tab[i] == code)
				result = cmd_tab[i];
		return result;
	endfunction

	function automatic ship_kbd_pkg::seg_t seg_for_cmd(input ship_kbd_pkg::ship_cmd_e c);
		case (c)
			ship_kbd_pkg::cmd_left:  return ship_kbd_pkg::seg_left;
			ship_kbd_pkg::cmd_right: return ship_kbd_pkg::seg_right;
			ship_kbd_pkg::cmd_down:  return ship_kbd_pkg::seg_down;
			ship_kbd_pkg::cmd_up:    return ship_kbd_pkg::seg_up;
			ship_kbd_pkg::cmd_fire:  return ship_kbd_pkg::seg_fire;
			default:                 return ship_kbd_pkg::seg_other; // arrow set
		endcase
	endfunction

	function automatic logic is_shift_code(input ship_kbd_pkg::scan_t code);
		return (code == ship_kbd_pkg::scan_shift_l) || (code == ship_kbd_pkg::scan_shift_r);
	endfunction

	task automatic flag_mismatch(input string name, input int unsigned exp_val,
		input int unsigned act_val);
		value_errors++;
		$display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp_val, act_val);
	endtask

	always @(byte_sent)
		exp_q.push_back(sent_byte);

	// outputs settle between rising edges, so compare on the falling one
	always @(negedge clk)
	begin : model_step
		ship_kbd_pkg::scan_t     code;
		logic                    have_code;
		logic                    exp_valid;
		logic                    exp_upper;
		ship_kbd_pkg::key_mode_e next_mode;
		if (reset)
		begin
			mode       = ship_kbd_pkg::mode_lower;
			held_shift = '0;
			caps_left  = 0;
			exp_cmd    = ship_kbd_pkg::cmd_up;
		end
		else
		begin
			have_code = 1'b0;
			code      = scan_code;
			exp_valid = 1'b0;
			next_mode = mode;
			exp_upper = (mode == ship_kbd_pkg::mode_shift) || (mode == ship_kbd_pkg::mode_caps);
			if (upper_case !== exp_upper) flag_mismatch("upper_case", exp_upper, upper_case);
			if (ship_cmd !== exp_cmd) flag_mismatch("ship_cmd", exp_cmd, ship_cmd);
			if (hex_seg !== seg_for_cmd(exp_cmd))
				flag_mismatch("hex_seg", seg_for_cmd(exp_cmd), hex_seg);
			if (rx_done)
			begin
				frames_seen++;
				if (exp_q.size() == 0)
				begin
					other_errors++;
					$display("error at t=%0t: rx_done pulsed with no frame on the line", $time);
				end
				else
				begin
					code      = exp_q.pop_front();
					have_code = 1'b1;
					if (scan_code !== code) flag_mismatch("scan_code", code, scan_code);
				end
			end
			if ((mode == ship_kbd_pkg::mode_caps) && (caps_left == 0))
				next_mode = ship_kbd_pkg::mode_lower; // caps count used up
			if (have_code)
			begin
				case (mode)
					ship_kbd_pkg::mode_lower:
					begin
						if (is_shift_code(code))
						begin
							held_shift = code;
							next_mode  = ship_kbd_pkg::mode_shift;
						end
						else if (code == ship_kbd_pkg::scan_caps)
						begin
							caps_left = ship_kbd_pkg::caps_presses;
							next_mode = ship_kbd_pkg::mode_caps;
						end
						else if (code == ship_kbd_pkg::scan_break)
							next_mode = ship_kbd_pkg::mode_skip_break;
						else
							exp_valid = 1'b1;
					end
					ship_kbd_pkg::mode_shift:
					begin
						if (code == ship_kbd_pkg::scan_break)
							next_mode = ship_kbd_pkg::mode_skip_shift_break;
						else if (!is_shift_code(code) && (code != ship_kbd_pkg::scan_caps))
							exp_valid = 1'b1;
					end
					ship_kbd_pkg::mode_skip_shift_break:
					begin
						if (code == held_shift) // the held shift let go
							next_mode = ship_kbd_pkg::mode_lower;
						else
							next_mode = ship_kbd_pkg::mode_shift;
					end
					ship_kbd_pkg::mode_caps:
					begin
						if (code == ship_kbd_pkg::scan_caps)
							caps_left--;
						else if (code == ship_kbd_pkg::scan_break)
							next_mode = ship_kbd_pkg::mode_skip_caps_break;
						else if (!is_shift_code(code))
							exp_valid = 1'b1;
					end
					ship_kbd_pkg::mode_skip_caps_break:
					begin
						if (code == ship_kbd_pkg::scan_caps)
							caps_left--; // caps release counts
						next_mode = ship_kbd_pkg::mode_caps;
					end
					default:
						next_mode = ship_kbd_pkg::mode_lower; // skip_break drops one code
				endcase
			end
			if (key_valid !== exp_valid) flag_mismatch("key_valid", exp_valid, key_valid);
			if (exp_valid)
				exp_cmd = cmd_for_key(code); // registered on the next edge
			mode = next_mode;
		end
	end

endmodule

// ==== dv/ship_kbd_tb.sv ====
// testbench top with clock, reset, xorshift key events, ps2 frame driver, watchdog and closing report
`timescale 1ns/1ps

module ship_kbd_tb;

	localparam int unsigned num_events  = 30;   // random events after the directed pass
	localparam int unsigned half_period = 20;   // clk cycles per ps2 clock phase
	localparam int unsigned idle_cycles = 40;   // line high between frames
	localparam int unsigned frame_len   = ship_kbd_pkg::frame_bits + 1; // with start bit

	logic clk;
	logic reset;
	logic ps2c;
	logic ps2d;
	ship_kbd_pkg::scan_t     scan_code;
	logic                    key_valid;
	logic                    upper_case;
	ship_kbd_pkg::ship_cmd_e ship_cmd;
	ship_kbd_pkg::seg_t      hex_seg;

	logic [31:0]         rng = 32'd77;       // xorshift state
	ship_kbd_pkg::scan_t frame_q[$];         // whole byte stream built up front
	int unsigned         n_frames = 0;
	int unsigned         cycle_cnt = 0;
	int unsigned         cycle_limit = 32'hffff_ffff; // real value set once the stream is known

	ship_kbd_pkg::scan_t key_tab [9] = '{ship_kbd_pkg::key_a, ship_kbd_pkg::key_d,
		ship_kbd_pkg::key_s, ship_kbd_pkg::key_w, ship_kbd_pkg::key_space,
		ship_kbd_pkg::key_up_arrow, ship_kbd_pkg::key_left_arrow,
		ship_kbd_pkg::key_down_arrow, ship_kbd_pkg::key_right_arrow};

	ship_kbd_top i_dut (
		.clk        (clk),
		.reset      (reset),
		.ps2c       (ps2c),
		.ps2d       (ps2d),
		.scan_code  (scan_code),
		.key_valid  (key_valid),
		.upper_case (upper_case),
		.ship_cmd   (ship_cmd),
		.hex_seg    (hex_seg)
	);

	ship_kbd_checker i_checker (
		.clk        (clk),
		.reset      (reset),
		.rx_done    (i_dut.rx_done),
		.scan_code  (scan_code),
		.key_valid  (key_valid),
		.upper_case (upper_case),
		.ship_cmd   (ship_cmd),
		.hex_seg    (hex_seg)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic int unsigned roll(input int unsigned range);
		rng = xorshift32(rng);
		return rng % range;
	endfunction

	// random byte that the tracker treats as a plain key
	function automatic ship_kbd_pkg::scan_t pick_other();
		ship_kbd_pkg::scan_t b;
		b = ship_kbd_pkg::scan_break;
		while ((b == ship_kbd_pkg::scan_break) || (b == ship_kbd_pkg::scan_shift_l) ||
			(b == ship_kbd_pkg::scan_shift_r) || (b == ship_kbd_pkg::scan_caps))
			b = 8'(roll(256));
		return b;
	endfunction

	function automatic void add_release(input ship_kbd_pkg::scan_t k);
		frame_q.push_back(ship_kbd_pkg::scan_break);
		frame_q.push_back(k);
	endfunction

	function automatic void add_tap(input ship_kbd_pkg::scan_t k);
		frame_q.push_back(k); // make
		add_release(k);
	endfunction

	// start 0, data lsb first, odd parity, stop 1
	task automatic send_frame(input ship_kbd_pkg::scan_t b);
		logic [10:0] bits;
		bits = {1'b1, ~^b, b, 1'b0};
		i_checker.sent_byte = b;
		-> i_checker.byte_sent;
		for (int i = 0; i < frame_len; i++)
		begin
			repeat (half_period / 2) @(posedge clk);
			ps2d <= bits[i]; // mid high phase
			repeat (half_period / 2) @(posedge clk);
			ps2c <= 1'b0;
			repeat (half_period) @(posedge clk);
			ps2c <= 1'b1;
		end
		repeat (idle_cycles) @(posedge clk);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial
	begin : watchdog
		wait (cycle_cnt >= cycle_limit);
		$display("timeout after %0d cycles, only %0d of %0d frames received",
			cycle_cnt, i_checker.frames_seen, n_frames);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin : main_seq
		int unsigned         kind;
		ship_kbd_pkg::scan_t k;
		ship_kbd_pkg::scan_t sh;
		ship_kbd_pkg::scan_t sh_other;
		reset = 1'b1;
		ps2c  = 1'b1;
		ps2d  = 1'b1;
		for (int i = 0; i < 8 + num_events; i++)
		begin
			kind = (i < 8) ? i : roll(8); // every kind once and then random
			k    = key_tab[roll(9)];
			sh   = roll(2) ? ship_kbd_pkg::scan_shift_r : ship_kbd_pkg::scan_shift_l;
			sh_other = (sh == ship_kbd_pkg::scan_shift_l) ? ship_kbd_pkg::scan_shift_r :
				ship_kbd_pkg::scan_shift_l;
			case (kind)
				4: add_tap(pick_other());
				5: // shift held over two keys and a release of the other shift
				begin
					frame_q.push_back(sh);
					add_tap(k);
					add_release(sh_other); // not the held one, stays shifted
					add_tap(pick_other());
					add_release(sh);
				end
				6: // caps press, release, press, release
				begin
					frame_q.push_back(ship_kbd_pkg::scan_caps);
					add_tap(k);
					add_release(ship_kbd_pkg::scan_caps);
					frame_q.push_back(ship_kbd_pkg::scan_caps);
					add_release(ship_kbd_pkg::scan_caps);
					add_tap(key_tab[roll(9)]);
				end
				7: // shift repeat and caps inside shift
				begin
					frame_q.push_back(sh);
					frame_q.push_back(sh);
					add_tap(ship_kbd_pkg::scan_caps);
					add_tap(k);
					add_release(sh);
				end
				default: add_tap(k);
			endcase
		end
		n_frames    = frame_q.size();
		cycle_limit = n_frames * (frame_len * 2 * half_period + idle_cycles) + idle_cycles + 4
			+ 2000;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (idle_cycles) @(posedge clk); // clock filter fills with ones
		foreach (frame_q[i])
			send_frame(frame_q[i]);
		wait (i_checker.frames_seen >= n_frames);
		repeat (2) @(posedge clk); // last command reaches a compare edge
		$display("closing report: %0d frames, %0d value errors, %0d other errors",
			n_frames, i_checker.value_errors, i_checker.other_errors);
		if ((i_checker.value_errors == 0) && (i_checker.other_errors == 0))
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== ship_kbd.f ====
hdl/ship_kbd_pkg.sv
hdl/ps2_rx.sv
hdl/key_mode_fsm.sv
hdl/ship_command_decode.sv
hdl/ship_kbd_top.sv
dv/ship_kbd_checker.sv
dv/ship_kbd_tb.sv

// ==== Bender.yml ====
package:
  name: ship_kbd

sources:
  - hdl/ship_kbd_pkg.sv
  - hdl/ps2_rx.sv
  - hdl/key_mode_fsm.sv
  - hdl/ship_command_decode.sv
  - hdl/ship_kbd_top.sv
  - target: simulation
    files:
      - dv/ship_kbd_checker.sv
      - dv/ship_kbd_tb.sv
